// File: dv/trace_adapter_cases.txt
# in: valid order rd_addr rd_wdata req we rvalid err debug_req irq
# out: x_wb haltreq nmi nmi_cause irq update(haltreq nmi irq, binary) bus_fault
1 0000000000000001 05 aaaa0001 1 0 0 0 0 00000000 00000020 0 0 400 00000000 000 0
1 0000000000000002 00 aaaa0002 1 0 0 0 0 00000000 00000000 0 0 400 00000000 000 0
0 0000000000000003 03 aaaa0003 1 1 0 0 0 00000000 00000000 0 0 400 00000000 000 0
1 0000000000000004 1f aaaa0004 0 0 1 0 0 00000000 80000000 0 0 400 00000000 000 0
0 0000000000000000 00 00000000 0 0 1 0 1 00000000 00000000 0 0 400 00000000 000 0
0 0000000000000000 00 00000000 0 0 1 1 0 00000000 00000000 1 0 400 00000000 100 0
0 0000000000000000 00 00000000 0 0 0 0 0 00000080 00000000 1 1 401 00000080 011 0
0 0000000000000000 00 00000000 0 0 0 0 0 000000a0 00000000 1 0 401 00000080 010 0
0 0000000000000000 00 00000000 1 0 0 0 0 00000080 00000000 1 0 401 00000080 000 0
0 0000000000000000 00 00000000 1 1 1 1 0 00000080 00000000 1 0 401 00000080 000 0
0 0000000000000000 00 00000000 0 0 1 0 0 00000080 00000000 1 1 400 00000080 010 0
0 0000000000000000 00 00000000 0 0 0 0 0 00000000 00000000 0 0 400 00000000 111 0
0 0000000000000000 00 00000000 0 0 1 0 0 00000000 00000000 0 0 400 00000000 000 1
0 0000000000000000 00 00000000 0 0 0 0 0 00000000 00000000 0 0 400 00000000 000 1
0 0000000000000000 00 00000000 0 0 0 0 0 00000000 00000000 0 0 400 00000000 000 1

// File: vlog.f
verilog/trace_pkg.sv
verilog/retire_capture.sv
verilog/bus_error_tracker.sv
verilog/halt_request_stretcher.sv
verilog/net_update_tracker.sv
verilog/trace_adapter_top.sv
dv/trace_adapter_assertions.sv
dv/trace_adapter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the trace adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module trace_adapter_tb -f vlog.f

./obj_dir/Vtrace_adapter_tb | tee sim.log

if grep -qx "sim passed" sim.log; then
   exit 0
fi
exit 1

// File: dv/trace_adapter_tb.sv
// Trace adapter testbench with clock, reset, file-driven cases, compare tasks and timeout
`timescale 1ns/1ns
`default_nettype none

module trace_adapter_tb;

   import trace_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 4;
   // Margin on top of one cycle per case line
   localparam int SLACK_CYCLES = 20;

   // One stimulus line with its expected outputs
   typedef struct packed {
      logic        valid;
      order_t      order;
      reg_idx_t    rd_addr;
      xlen_t       rd_wdata;
      logic        req;
      logic        we;
      logic        rvalid;
      logic        err;
      logic        dbg;
      irq_vec_t    irq;
      reg_mask_t   exp_x_wb;
      net_state_t  exp_net;
      net_update_t exp_upd;
      logic        exp_fault;
   } case_t;

   logic        rvvi;
   logic        rst_n_i;
   retire_in_t  retire_i;
   logic        data_req_i;
   logic        data_we_i;
   logic        data_rvalid_i;
   logic        data_err_i;
   logic        debug_req_i;
   irq_vec_t    irq_i;
   trace_rec_t  trace_o;
   net_state_t  net_o;
   net_update_t net_update_o;
   logic        bus_fault_o;

   case_t cases[$];
   int    trace_errors  = 0;
   int    net_errors    = 0;
   int    update_errors = 0;
   int    fault_errors  = 0;
   int    file_errors   = 0;
   int    cycle_count   = 0;
   int    cycle_limit   = SLACK_CYCLES;

   trace_adapter_top #(
      .HALT_HOLD_CYCLES  (5),
      .OUTSTANDING_DEPTH (4)
   ) dut_i (
      .rvvi          (rvvi),
      .rst_n_i       (rst_n_i),
      .retire_i      (retire_i),
      .data_req_i    (data_req_i),
      .data_we_i     (data_we_i),
      .data_rvalid_i (data_rvalid_i),
      .data_err_i    (data_err_i),
      .debug_req_i   (debug_req_i),
      .irq_i         (irq_i),
      .trace_o       (trace_o),
      .net_o         (net_o),
      .net_update_o  (net_update_o),
      .bus_fault_o   (bus_fault_o)
   );

   //////////////////////////////
   // Clock and watchdog

   initial begin
      rvvi = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) rvvi = ~rvvi;
      end
   end

   always @(posedge rvvi) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("run stopped after %0d cycles with cases still pending", cycle_count);
         $display("sim failed");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus helpers

   // Fields the file leaves out follow from the order number
   function automatic retire_in_t make_retire(input case_t c);
      retire_in_t r;
      r.valid    = c.valid;
      r.order    = c.order;
      r.insn     = {c.order[15:0], 16'h0093};
      r.trap     = c.order[2];
      r.intr     = c.order[1];
      r.mode     = 2'b11;
      r.ixl      = 2'b01;
      r.pc_rdata = 32'h8000_0000 + {c.order[29:0], 2'b00};
      r.pc_wdata = r.pc_rdata + 32'd4;
      r.rd_addr  = c.rd_addr;
      r.rd_wdata = c.rd_wdata;
      return r;
   endfunction

   // Record expected one edge later with the mask taken from the file
   function automatic trace_rec_t expect_trace(input case_t c);
      retire_in_t r;
      trace_rec_t t;
      r          = make_retire(c);
      t.valid    = r.valid;
      t.order    = r.order;
      t.insn     = r.insn;
      t.trap     = r.trap;
      t.intr     = r.intr;
      t.mode     = r.mode;
      t.ixl      = r.ixl;
      t.pc_rdata = r.pc_rdata;
      t.pc_wdata = r.pc_wdata;
      t.rd_wdata = r.rd_wdata;
      t.x_wb     = c.exp_x_wb;
      return t;
   endfunction

   task automatic drive_case(input case_t c);
      retire_i      = make_retire(c);
      data_req_i    = c.req;
      data_we_i     = c.we;
      data_rvalid_i = c.rvalid;
      data_err_i    = c.err;
      debug_req_i   = c.dbg;
      irq_i         = c.irq;
   endtask

   task automatic load_cases(output bit ok);
      int          fd;
      int          n;
      int          line_no;
      string       line;
      case_t       c;
      logic        v;
      logic        req;
      logic        we;
      logic        rv;
      logic        err;
      logic        dbg;
      logic        halt;
      logic        nmi;
      logic        fault;
      order_t      ord;
      reg_idx_t    rd;
      xlen_t       wd;
      irq_vec_t    irq;
      irq_vec_t    eirq;
      reg_mask_t   xwb;
      nmi_cause_t  cause;
      net_update_t upd;
      ok      = 1'b1;
      line_no = 0;
      fd      = $fopen("dv/trace_adapter_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open the case file dv/trace_adapter_cases.txt");
         ok = 1'b0;
      end else begin
         while ($fgets(line, fd) != 0) begin
            line_no = line_no + 1;
            // Blank lines and column notes
            if (line.len() > 1 && line[0] != 8'h23) begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b %h",
                           v, ord, rd, wd, req, we, rv, err, dbg, irq,
                           xwb, halt, nmi, cause, eirq, upd, fault);
               if (n != 17) begin
                  $display("case file line %0d has %0d fields instead of 17", line_no, n);
                  ok = 1'b0;
               end else begin
                  c.valid             = v;
                  c.order             = ord;
                  c.rd_addr           = rd;
                  c.rd_wdata          = wd;
                  c.req               = req;
                  c.we                = we;
                  c.rvalid            = rv;
                  c.err               = err;
                  c.dbg               = dbg;
                  c.irq               = irq;
                  c.exp_x_wb          = xwb;
                  c.exp_net.haltreq   = halt;
                  c.exp_net.nmi       = nmi;
                  c.exp_net.nmi_cause = cause;
                  c.exp_net.irq       = eirq;
                  c.exp_upd           = upd;
                  c.exp_fault         = fault;
                  cases.push_back(c);
               end
            end
         end
         $fclose(fd);
         if (cases.size() == 0) begin
            $display("case file holds no stimulus lines");
            ok = 1'b0;
         end
      end
   endtask

   //////////////////////////////
   // Checks

   task automatic compare_trace(input string name, input trace_rec_t got,
                                input trace_rec_t exp);
      if (got !== exp) begin
         trace_errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_net(input string name, input net_state_t got,
                              input net_state_t exp);
      if (got !== exp) begin
         net_errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_update(input string name, input net_update_t got,
                                 input net_update_t exp);
      if (got !== exp) begin
         update_errors++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_fault(input int idx, input logic expected);
      if (bus_fault_o !== expected) begin
         fault_errors++;
         $display("at %0t the bus fault flag is %b on case %0d but should be %b",
                  $time, bus_fault_o, idx, expected);
      end
   endtask

   //////////////////////////////
   // Sequence

   task automatic apply_reset();
      rst_n_i = 1'b0;
      repeat (RESET_CYCLES) @(negedge rvvi);
      rst_n_i = 1'b1;
   endtask

   // Drive on the falling edge and sample a quarter period after the rising edge
   task automatic run_cases();
      case_t c;
      for (int i = 0; i < cases.size(); i++) begin
         c = cases[i];
         @(negedge rvvi);
         drive_case(c);
         @(posedge rvvi);
         #(CLK_PERIOD / 4);
         compare_trace("trace_o", trace_o, expect_trace(c));
         compare_net("net_o", net_o, c.exp_net);
         compare_update("net_update_o", net_update_o, c.exp_upd);
         check_fault(i, c.exp_fault);
      end
   endtask

   initial begin
      bit loaded;
      rst_n_i       = 1'b0;
      retire_i      = '0;
      data_req_i    = 1'b0;
      data_we_i     = 1'b0;
      data_rvalid_i = 1'b0;
      data_err_i    = 1'b0;
      debug_req_i   = 1'b0;
      irq_i         = '0;
      load_cases(loaded);
      cycle_limit = cases.size() + SLACK_CYCLES;
      if (loaded) begin
         apply_reset();
         run_cases();
      end else begin
         file_errors++;
      end
      $display("errors: trace %0d, net %0d, update %0d, fault %0d, file %0d",
               trace_errors, net_errors, update_errors, fault_errors, file_errors);
      if (trace_errors + net_errors + update_errors + fault_errors + file_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/trace_adapter_assertions.sv
// Concurrent checks on trace adapter outputs, bound to the top level
`timescale 1ns/1ns
`default_nettype none

module trace_adapter_assertions (
   input wire logic                  rvvi,
   input wire logic                  rst_n_i,
   input wire trace_pkg::trace_rec_t  trace_i,
   input wire trace_pkg::net_state_t  net_i,
   input wire trace_pkg::net_update_t net_update_i
);

   import trace_pkg::*;

   // At most one destination, never x0
   assert property (@(posedge rvvi) disable iff (!rst_n_i)
      $onehot0(trace_i.x_wb) && !trace_i.x_wb[0])
      else $error("x_wb is not one-hot or marks x0");

   // Each flag is a single pulse per change of its net
   assert property (@(posedge rvvi) disable iff (!rst_n_i)
      net_update_i.haltreq == (net_i.haltreq != $past(net_i.haltreq)))
      else $error("haltreq update flag out of step with net_o");

   assert property (@(posedge rvvi) disable iff (!rst_n_i)
      net_update_i.nmi == (net_i.nmi != $past(net_i.nmi)))
      else $error("nmi update flag out of step with net_o");

   assert property (@(posedge rvvi) disable iff (!rst_n_i)
      net_update_i.irq == (net_i.irq != $past(net_i.irq)))
      else $error("irq update flag out of step with net_o");

   // Cause is load or store while nmi is up
   assert property (@(posedge rvvi) disable iff (!rst_n_i)
      net_i.nmi |-> (net_i.nmi_cause == NMI_CAUSE_LOAD ||
                     net_i.nmi_cause == NMI_CAUSE_STORE))
      else $error("nmi raised with an unknown cause");

endmodule

bind trace_adapter_top trace_adapter_assertions u_assertions (
   .rvvi         (rvvi),
   .rst_n_i      (rst_n_i),
   .trace_i      (trace_o),
   .net_i        (net_o),
   .net_update_i (net_update_o)
);

`default_nettype wire

// File: verilog/trace_adapter_top.sv
// Trace adapter top level: retirement capture, halt stretch, bus-error NMI, net tracking
`timescale 1ns/1ns
`default_nettype none

module trace_adapter_top #(
   parameter int unsigned HALT_HOLD_CYCLES  = 5,
   parameter int unsigned OUTSTANDING_DEPTH = 4
) (
   input  wire logic                 rvvi,
   input  wire logic                 rst_n_i,
   // Retirement port
   input  wire trace_pkg::retire_in_t retire_i,
   // Data bus side-band
   input  wire logic                 data_req_i,
   input  wire logic                 data_we_i,
   input  wire logic                 data_rvalid_i,
   input  wire logic                 data_err_i,
   // Debug and interrupts
   input  wire logic                 debug_req_i,
   input  wire trace_pkg::irq_vec_t  irq_i,
   // Trace and reference-model nets
   output trace_pkg::trace_rec_t     trace_o,
   output trace_pkg::net_state_t     net_o,
   output trace_pkg::net_update_t    net_update_o,
   output logic                      bus_fault_o
);

   import trace_pkg::*;

   // Sources feeding the net register stage
   logic       nmi;
   nmi_cause_t nmi_cause;
   logic       haltreq;

   //////////////////////////////
   // Retirement

   retire_capture u_retire_capture (
      .rvvi     (rvvi),
      .rst_n_i  (rst_n_i),
      .retire_i (retire_i),
      .trace_o  (trace_o)
   );

   //////////////////////////////
   // Net sources

   bus_error_tracker #(
      .OUTSTANDING_DEPTH (OUTSTANDING_DEPTH)
   ) u_bus_error_tracker (
      .rvvi          (rvvi),
      .rst_n_i       (rst_n_i),
      .data_req_i    (data_req_i),
      .data_we_i     (data_we_i),
      .data_rvalid_i (data_rvalid_i),
      .data_err_i    (data_err_i),
      .nmi_o         (nmi),
      .nmi_cause_o   (nmi_cause),
      .bus_fault_o   (bus_fault_o)
   );

   halt_request_stretcher #(
      .HALT_HOLD_CYCLES (HALT_HOLD_CYCLES)
   ) u_halt_request_stretcher (
      .rvvi        (rvvi),
      .rst_n_i     (rst_n_i),
      .debug_req_i (debug_req_i),
      .haltreq_o   (haltreq)
   );

   // irq goes in unregistered, one edge to net_o
   net_update_tracker u_net_update_tracker (
      .rvvi         (rvvi),
      .rst_n_i      (rst_n_i),
      .haltreq_i    (haltreq),
      .nmi_i        (nmi),
      .nmi_cause_i  (nmi_cause),
      .irq_i        (irq_i),
      .net_o        (net_o),
      .net_update_o (net_update_o)
   );

endmodule

`default_nettype wire

// File: verilog/net_update_tracker.sv
// Net value register stage with one-cycle change flags per net
`timescale 1ns/1ns
`default_nettype none

module net_update_tracker (
   input  wire logic                 rvvi,
   input  wire logic                 rst_n_i,
   input  wire logic                 haltreq_i,
   input  wire logic                 nmi_i,
   input  wire trace_pkg::nmi_cause_t nmi_cause_i,
   input  wire trace_pkg::irq_vec_t  irq_i,
   output trace_pkg::net_state_t     net_o,
   output trace_pkg::net_update_t    net_update_o
);

   import trace_pkg::*;

   net_state_t  net_d;
   net_update_t update_d;

   //////////////////////////////
   // Next values

   always_comb begin
      net_d.haltreq   = haltreq_i;
      net_d.nmi       = nmi_i;
      net_d.nmi_cause = nmi_cause_i;
      // Lines outside the model are dropped here
      net_d.irq       = irq_i & IRQ_USED_MASK;
   end

   // Compare against what net_o shows now
   always_comb begin
      update_d.haltreq = (net_d.haltreq != net_o.haltreq);
      update_d.nmi     = (net_d.nmi != net_o.nmi);
      // Both sides already masked
      update_d.irq     = (net_d.irq != net_o.irq);
   end

   //////////////////////////////
   // Register stage

   // Flags land with the first differing net_o value
   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         net_o        <= '0;
         net_update_o <= '0;
      end else begin
         net_o        <= net_d;
         net_update_o <= update_d;
      end
   end

endmodule

`default_nettype wire

// File: verilog/halt_request_stretcher.sv
// Debug halt request register with a fixed hold after the request falls
`timescale 1ns/1ns
`default_nettype none

module halt_request_stretcher #(
   parameter int unsigned HALT_HOLD_CYCLES = 5
) (
   input  wire logic rvvi,
   input  wire logic rst_n_i,
   input  wire logic debug_req_i,
   output logic      haltreq_o
);

   localparam int unsigned CNT_W = $clog2(HALT_HOLD_CYCLES + 1);
   localparam logic [CNT_W-1:0] HOLD_C = CNT_W'(HALT_HOLD_CYCLES);

   // Edges left before haltreq may drop
   logic [CNT_W-1:0] hold_cnt_q;
   logic             hold_active;

   assign hold_active = (hold_cnt_q != '0);

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_cnt_q <= '0;
         haltreq_o  <= 1'b0;
      end else begin
         // Reload while requested, count down afterwards
         if (debug_req_i) begin
            hold_cnt_q <= HOLD_C;
         end else if (hold_active) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
         end
         // High for the request plus HALT_HOLD_CYCLES edges
         haltreq_o <= debug_req_i || hold_active;
      end
   end

endmodule

`default_nettype wire

// File: verilog/bus_error_tracker.sv
// Outstanding data access queue, bus-error NMI with load/store cause, sticky misuse fault
`timescale 1ns/1ns
`default_nettype none

module bus_error_tracker #(
   parameter int unsigned OUTSTANDING_DEPTH = 4
) (
   input  wire logic             rvvi,
   input  wire logic             rst_n_i,
   input  wire logic             data_req_i,
   input  wire logic             data_we_i,
   input  wire logic             data_rvalid_i,
   input  wire logic             data_err_i,
   output logic                  nmi_o,
   output trace_pkg::nmi_cause_t nmi_cause_o,
   output logic                  bus_fault_o
);

   import trace_pkg::*;

   // Depth is a power of two, so pointers wrap by themselves
   localparam int unsigned PTR_W = $clog2(OUTSTANDING_DEPTH);
   localparam int unsigned CNT_W = PTR_W + 1;
   localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(OUTSTANDING_DEPTH);

   // One bit per access, set for a store
   logic [OUTSTANDING_DEPTH-1:0] is_store_q;
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   logic empty;
   logic full;
   logic pop_fault;
   logic push_fault;
   logic do_push;
   logic do_pop;
   logic err_rsp;

   //////////////////////////////
   // Queue control

   assign empty = (count_q == '0);
   assign full  = (count_q == DEPTH_C);

   // Response with nothing outstanding
   assign pop_fault  = data_rvalid_i && empty;
   // No room and no pop to free a slot
   assign push_fault = data_req_i && full && !data_rvalid_i;

   // Misuse leaves the queue as it was
   assign do_push = data_req_i && !pop_fault && !push_fault;
   assign do_pop  = data_rvalid_i && !pop_fault && !push_fault;

   // Error only counts with a response
   assign err_rsp = data_rvalid_i && data_err_i;

   // Direction storage
   always_ff @(posedge rvvi) begin
      if (do_push) begin
         is_store_q[wr_ptr_q] <= data_we_i;
      end
   end

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop keeps the count
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   //////////////////////////////
   // NMI and fault

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         nmi_o       <= 1'b0;
         nmi_cause_o <= NMI_CAUSE_LOAD;
         bus_fault_o <= 1'b0;
      end else begin
         // High for each error response, low after the first clean edge
         nmi_o <= err_rsp;
         if (err_rsp) begin
            // Head entry is the access being completed
            nmi_cause_o <= (!empty && is_store_q[rd_ptr_q]) ? NMI_CAUSE_STORE
                                                            : NMI_CAUSE_LOAD;
         end
         // Sticky until reset
         if (pop_fault || push_fault) begin
            bus_fault_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/retire_capture.sv
// Retirement capture: registers retired instruction fields and decodes the writeback mask
`timescale 1ns/1ns
`default_nettype none

module retire_capture (
   input  wire logic                 rvvi,
   input  wire logic                 rst_n_i,
   input  wire trace_pkg::retire_in_t retire_i,
   output trace_pkg::trace_rec_t     trace_o
);

   import trace_pkg::*;

   trace_rec_t rec_d;
   trace_rec_t rec_q;
   reg_mask_t  x_wb_d;
   reg_mask_t  x_wb_q;
   logic       valid_q;

   // One-hot destination, x0 is never written
   always_comb begin
      x_wb_d = '0;
      if (retire_i.valid && (retire_i.rd_addr != '0)) begin
         x_wb_d[retire_i.rd_addr] = 1'b1;
      end
   end

   // Record as seen on the port this cycle
   always_comb begin
      rec_d.valid    = retire_i.valid;
      rec_d.order    = retire_i.order;
      rec_d.insn     = retire_i.insn;
      rec_d.trap     = retire_i.trap;
      rec_d.intr     = retire_i.intr;
      rec_d.mode     = retire_i.mode;
      rec_d.ixl      = retire_i.ixl;
      rec_d.pc_rdata = retire_i.pc_rdata;
      rec_d.pc_wdata = retire_i.pc_wdata;
      rec_d.rd_wdata = retire_i.rd_wdata;
      rec_d.x_wb     = x_wb_d;
   end

   // Payload, sampled every cycle
   always_ff @(posedge rvvi) begin
      rec_q <= rec_d;
   end

   // Valid and writeback mask
   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         x_wb_q  <= '0;
      end else begin
         valid_q <= retire_i.valid;
         x_wb_q  <= x_wb_d;
      end
   end

   // Control fields override the payload copy
   always_comb begin
      trace_o       = rec_q;
      trace_o.valid = valid_q;
      trace_o.x_wb  = x_wb_q;
   end

endmodule

`default_nettype wire

// File: verilog/trace_pkg.sv
// Trace adapter widths, vector types, NMI and IRQ constants, packed record structs
`default_nettype none

package trace_pkg;

   //////////////////////////////
   // Vector types

   // Data word or address
   typedef logic [31:0] xlen_t;
   // General register number
   typedef logic [4:0]  reg_idx_t;
   // One bit per general register
   typedef logic [31:0] reg_mask_t;
   // Retirement sequence number
   typedef logic [63:0] order_t;
   // Interrupt lines
   typedef logic [31:0] irq_vec_t;
   // NMI cause code
   typedef logic [10:0] nmi_cause_t;

   //////////////////////////////
   // Constants

   // Bus error on a load or on a store
   localparam nmi_cause_t NMI_CAUSE_LOAD  = 11'd1024;
   localparam nmi_cause_t NMI_CAUSE_STORE = 11'd1025;

   // Software, timer, external and the sixteen local lines
   localparam irq_vec_t IRQ_USED_MASK = 32'hFFFF_0888;

   //////////////////////////////
   // Records

   // Raw retirement port from the core
   typedef struct packed {
      logic     valid;
      order_t   order;
      xlen_t    insn;
      logic     trap;
      logic     intr;
      logic [1:0] mode;
      logic [1:0] ixl;
      xlen_t    pc_rdata;
      xlen_t    pc_wdata;
      reg_idx_t rd_addr;
      xlen_t    rd_wdata;
   } retire_in_t;

   // Registered trace record, register number replaced by the writeback mask
   typedef struct packed {
      logic      valid;
      order_t    order;
      xlen_t     insn;
      logic      trap;
      logic      intr;
      logic [1:0] mode;
      logic [1:0] ixl;
      xlen_t     pc_rdata;
      xlen_t     pc_wdata;
      xlen_t     rd_wdata;
      reg_mask_t x_wb;
   } trace_rec_t;

   // Reference-model net values
   typedef struct packed {
      logic       haltreq;
      logic       nmi;
      nmi_cause_t nmi_cause;
      irq_vec_t   irq;
   } net_state_t;

   // One-cycle change flags
   typedef struct packed {
      logic haltreq;
      logic nmi;
      logic irq;
   } net_update_t;

endpackage

`default_nettype wire
